//--- logic/ctlb_pkg.sv
`default_nettype none

package ctlb_pkg;

  // --------------------------------------------------
  // widths.
  // --------------------------------------------------
  localparam int VPN_WIDTH  = 40;
  localparam int SET_BITS   = 6;
  localparam int TAG_WIDTH  = VPN_WIDTH - SET_BITS;
  localparam int ASID_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int GLOBAL_BIT = 0;
  localparam int WAYS       = 4;

  // --------------------------------------------------
  // entry word, low to high: rank, data, valid, asid, tag.
  // --------------------------------------------------
  localparam int ENTRY_RANK_LSB  = 0;
  localparam int ENTRY_DATA_LSB  = ENTRY_RANK_LSB + 2;
  localparam int ENTRY_VALID_BIT = ENTRY_DATA_LSB + DATA_WIDTH;
  localparam int ENTRY_ASID_LSB  = ENTRY_VALID_BIT + 1;
  localparam int ENTRY_TAG_LSB   = ENTRY_ASID_LSB + ASID_WIDTH;
  localparam int ENTRY_WIDTH     = ENTRY_TAG_LSB + TAG_WIDTH;

  // --------------------------------------------------
  // csr bus.
  // --------------------------------------------------
  localparam int CSR_ADDR_WIDTH = 16;
  localparam int CSR_DATA_WIDTH = 64;

  // page csr, asid in bits 15:0.
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_PAGE   = 16'h0103;
  // flags csr, bit 0 enables virtualisation.
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MFLAGS = 16'h0300;

endpackage

`default_nettype wire

//--- logic/ctlb_lookup_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ctlb_lookup_if #(
  parameter int VPN_WIDTH  = ctlb_pkg::VPN_WIDTH,
  parameter int DATA_WIDTH = ctlb_pkg::DATA_WIDTH,
  parameter int ASID_WIDTH = ctlb_pkg::ASID_WIDTH
);

  // lookup vpn, or the set counter while sweeping.
  logic [VPN_WIDTH-1:0]  vpn;
  logic [ASID_WIDTH-1:0] asid;
  logic                  lookup_en;
  logic                  stall;
  logic                  sweep;
  logic                  fill_en;
  logic [DATA_WIDTH-1:0] fill_data;
  // 0 during a fill write, 3 on a miss.
  logic [1:0]            hit_rank;

  modport source (output vpn, asid, lookup_en, stall, sweep, fill_en, fill_data,
                  hit_rank);

  modport way (input vpn, asid, lookup_en, stall, sweep, fill_en, fill_data,
               hit_rank);

endinterface

`default_nettype wire

//--- logic/ctlb_ram.sv
`timescale 1ns/1ns
`default_nettype none

module ctlb_ram #(
  parameter int VPN_WIDTH  = ctlb_pkg::VPN_WIDTH,
  parameter int DATA_WIDTH = ctlb_pkg::DATA_WIDTH,
  parameter int ASID_WIDTH = ctlb_pkg::ASID_WIDTH,
  localparam int ENTRY_WIDTH = VPN_WIDTH - ctlb_pkg::SET_BITS + ASID_WIDTH + 1 +
                               DATA_WIDTH + 2
)(
  input  wire                          clk,
  input  wire [ctlb_pkg::SET_BITS-1:0] addr,
  output logic [ENTRY_WIDTH-1:0]       rdata,
  input  wire [ENTRY_WIDTH-1:0]        wdata,
  input  wire                          we
);

  logic [ENTRY_WIDTH-1:0] mem [0:(1 << ctlb_pkg::SET_BITS)-1];

  // read and write share the address.
  assign rdata = mem[addr];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[addr] <= wdata;
  end

endmodule

`default_nettype wire

//--- logic/ctlb_rank.sv
`timescale 1ns/1ns
`default_nettype none

module ctlb_rank (
  input  wire [1:0]  old_rank,
  input  wire [1:0]  hit_rank,
  output logic [1:0] new_rank
);

  // touched way becomes most recent.
  // ways above it close the gap.
  always_comb
  begin
    if (old_rank == hit_rank)
      new_rank = 2'd3;
    else if (old_rank > hit_rank)
      new_rank = old_rank - 2'd1;
    else
      new_rank = old_rank;
  end

endmodule

`default_nettype wire

//--- logic/csr_watch.sv
`timescale 1ns/1ns
`default_nettype none

module csr_watch #(
  parameter logic [ctlb_pkg::CSR_ADDR_WIDTH-1:0] CSR_ID = '0
)(
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 csr_en,
  input  wire [ctlb_pkg::CSR_ADDR_WIDTH-1:0]  csr_addr,
  input  wire [ctlb_pkg::CSR_DATA_WIDTH-1:0]  csr_wdata,
  output logic [ctlb_pkg::CSR_DATA_WIDTH-1:0] value
);

  // local copy of one csr.
  always_ff @(posedge clk)
  begin
    if (rst)
      value <= '0;
    else if (csr_en && csr_addr == CSR_ID)
      value <= csr_wdata;
  end

endmodule

`default_nettype wire

//--- logic/ctlb_way.sv
`timescale 1ns/1ns
`default_nettype none

module ctlb_way #(
  parameter int WAY_ID     = 0,
  parameter int VPN_WIDTH  = ctlb_pkg::VPN_WIDTH,
  parameter int DATA_WIDTH = ctlb_pkg::DATA_WIDTH,
  parameter int ASID_WIDTH = ctlb_pkg::ASID_WIDTH
)(
  input  wire                   clk,
  input  wire                   rst,
  ctlb_lookup_if.way            bus,
  input  wire [1:0]             new_rank,
  output logic                  hit,
  output logic [1:0]            rank,
  output logic [DATA_WIDTH-1:0] data
);

  localparam int TAG_WIDTH = VPN_WIDTH - ctlb_pkg::SET_BITS;

  logic [ctlb_pkg::SET_BITS-1:0]    set_idx;
  logic [TAG_WIDTH-1:0]             lookup_tag;
  logic [ctlb_pkg::ENTRY_WIDTH-1:0] rd_word;
  logic [ctlb_pkg::ENTRY_WIDTH-1:0] fresh_word;
  logic [ctlb_pkg::ENTRY_WIDTH-1:0] same_word;
  logic [ctlb_pkg::ENTRY_WIDTH-1:0] init_word;
  logic [ctlb_pkg::ENTRY_WIDTH-1:0] wr_word;
  logic [TAG_WIDTH-1:0]             ent_tag;
  logic [ASID_WIDTH-1:0]            ent_asid;
  logic                             ent_valid;
  logic [DATA_WIDTH-1:0]            ent_data;
  logic                             fill_pend;
  logic [DATA_WIDTH-1:0]            fill_data_q;
  logic                             we;

  assign set_idx    = bus.vpn[ctlb_pkg::SET_BITS-1:0];
  assign lookup_tag = bus.vpn[VPN_WIDTH-1:ctlb_pkg::SET_BITS];

  // --------------------------------------------------
  // stored entry fields.
  // --------------------------------------------------
  assign ent_tag   = rd_word[ctlb_pkg::ENTRY_TAG_LSB +: TAG_WIDTH];
  assign ent_asid  = rd_word[ctlb_pkg::ENTRY_ASID_LSB +: ASID_WIDTH];
  assign ent_valid = rd_word[ctlb_pkg::ENTRY_VALID_BIT];
  assign ent_data  = rd_word[ctlb_pkg::ENTRY_DATA_LSB +: DATA_WIDTH];
  assign rank      = rd_word[ctlb_pkg::ENTRY_RANK_LSB +: 2];
  assign data      = ent_data;

  // global entries ignore the asid.
  assign hit = ent_valid && (ent_tag == lookup_tag) &&
               ((ent_asid == bus.asid) || ent_data[ctlb_pkg::GLOBAL_BIT]);

  // --------------------------------------------------
  // rewrite candidates.
  // --------------------------------------------------
  always_comb
  begin
    fresh_word = '0;
    fresh_word[ctlb_pkg::ENTRY_TAG_LSB +: TAG_WIDTH]   = lookup_tag;
    fresh_word[ctlb_pkg::ENTRY_ASID_LSB +: ASID_WIDTH] = bus.asid;
    fresh_word[ctlb_pkg::ENTRY_VALID_BIT]              = 1'b1;
    fresh_word[ctlb_pkg::ENTRY_DATA_LSB +: DATA_WIDTH] = fill_data_q;
    fresh_word[ctlb_pkg::ENTRY_RANK_LSB +: 2]          = 2'd3;
  end

  always_comb
  begin
    same_word = rd_word;
    same_word[ctlb_pkg::ENTRY_RANK_LSB +: 2] = new_rank;
  end

  always_comb
  begin
    init_word = '0;
    init_word[ctlb_pkg::ENTRY_RANK_LSB +: 2] = 2'(WAY_ID);
  end

  // the victim is the way at rank 0.
  always_comb
  begin
    if (bus.sweep)
      wr_word = init_word;
    else if (fill_pend && rank == 2'd0)
      wr_word = fresh_word;
    else
      wr_word = same_word;
  end

  assign we = bus.sweep || (!bus.stall && (bus.lookup_en || fill_pend));

  ctlb_ram #(
    .VPN_WIDTH  (VPN_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ASID_WIDTH (ASID_WIDTH)
  ) ram (
    .clk   (clk),
    .addr  (set_idx),
    .rdata (rd_word),
    .wdata (wr_word),
    .we    (we)
  );

  // --------------------------------------------------
  // fill request, held across stalls.
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
      fill_pend <= 1'b0;
    else if (!bus.stall)
      fill_pend <= bus.fill_en;
  end

  always_ff @(posedge clk)
  begin
    if (!bus.stall && bus.fill_en)
      fill_data_q <= bus.fill_data;
  end

endmodule

`default_nettype wire

//--- logic/ctlb.sv
`timescale 1ns/1ns
`default_nettype none

module ctlb #(
  parameter int VPN_WIDTH  = ctlb_pkg::VPN_WIDTH,
  parameter int DATA_WIDTH = ctlb_pkg::DATA_WIDTH,
  parameter int ASID_WIDTH = ctlb_pkg::ASID_WIDTH
)(
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                lookup_en,
  input  wire                                stall,
  input  wire [VPN_WIDTH-1:0]                vpn,
  output logic                               read_hit,
  output logic [DATA_WIDTH-1:0]              read_data,
  input  wire                                fill_en,
  input  wire [DATA_WIDTH-1:0]               fill_data,
  input  wire                                csr_en,
  input  wire [ctlb_pkg::CSR_ADDR_WIDTH-1:0] csr_addr,
  input  wire [ctlb_pkg::CSR_DATA_WIDTH-1:0] csr_wdata
);

  localparam int WAYS = ctlb_pkg::WAYS;

  logic                                sweeping;
  logic [ctlb_pkg::SET_BITS-1:0]       sweep_cnt;
  logic                                fill_pend;
  logic [WAYS-1:0]                     way_hit;
  logic [1:0]                          way_rank [WAYS];
  logic [1:0]                          new_rank [WAYS];
  logic [DATA_WIDTH-1:0]               way_data [WAYS];
  logic [DATA_WIDTH-1:0]               sel_data;
  logic [1:0]                          sel_rank;
  logic [ctlb_pkg::CSR_DATA_WIDTH-1:0] page_value;
  logic [ctlb_pkg::CSR_DATA_WIDTH-1:0] flags_value;

  ctlb_lookup_if #(
    .VPN_WIDTH  (VPN_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ASID_WIDTH (ASID_WIDTH)
  ) bus ();

  // --------------------------------------------------
  // init sweep, one set per cycle.
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sweeping  <= 1'b1;
      sweep_cnt <= '0;
    end
    else if (sweeping)
    begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == '1)
        sweeping <= 1'b0;
    end
  end

  // mirrors the pending fill held in each way.
  always_ff @(posedge clk)
  begin
    if (rst)
      fill_pend <= 1'b0;
    else if (!stall)
      fill_pend <= fill_en;
  end

  // --------------------------------------------------
  // current asid from the watched csrs.
  // --------------------------------------------------
  csr_watch #(.CSR_ID(ctlb_pkg::CSR_PAGE)) page_watch (
    .clk       (clk),
    .rst       (rst),
    .csr_en    (csr_en),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .value     (page_value)
  );

  csr_watch #(.CSR_ID(ctlb_pkg::CSR_MFLAGS)) flags_watch (
    .clk       (clk),
    .rst       (rst),
    .csr_en    (csr_en),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .value     (flags_value)
  );

  // --------------------------------------------------
  // broadcast bus.
  // --------------------------------------------------
  assign bus.vpn       = sweeping ? VPN_WIDTH'(sweep_cnt) : vpn;
  // guest asid has bit 0 flipped.
  assign bus.asid      = flags_value[0] ? (page_value[ASID_WIDTH-1:0] ^ ASID_WIDTH'(1)) : '0;
  assign bus.lookup_en = lookup_en;
  assign bus.stall     = stall;
  assign bus.sweep     = sweeping;
  assign bus.fill_en   = fill_en;
  assign bus.fill_data = fill_data;
  assign bus.hit_rank  = fill_pend ? 2'd0 : (read_hit ? sel_rank : 2'd3);

  generate
    for (genvar w = 0; w < WAYS; w++)
    begin : g_way
      ctlb_way #(
        .WAY_ID     (w),
        .VPN_WIDTH  (VPN_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ASID_WIDTH (ASID_WIDTH)
      ) way (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .new_rank (new_rank[w]),
        .hit      (way_hit[w]),
        .rank     (way_rank[w]),
        .data     (way_data[w])
      );

      ctlb_rank rank_upd (
        .old_rank (way_rank[w]),
        .hit_rank (bus.hit_rank),
        .new_rank (new_rank[w])
      );
    end
  endgenerate

  // --------------------------------------------------
  // hit merge.
  // --------------------------------------------------
  always_comb
  begin
    sel_data = '0;
    sel_rank = 2'd3;
    for (int w = 0; w < WAYS; w++)
    begin
      if (way_hit[w])
      begin
        sel_data = way_data[w];
        sel_rank = way_rank[w];
      end
    end
  end

  assign read_hit  = (|way_hit) && !sweeping;
  assign read_data = read_hit ? sel_data : '0;

endmodule

`default_nettype wire

//--- verification/ctlb_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ctlb_tb;

  localparam int VPN_W  = ctlb_pkg::VPN_WIDTH;
  localparam int DATA_W = ctlb_pkg::DATA_WIDTH;

  logic              clk;
  logic              rst;
  logic              lookup_en;
  logic              stall;
  logic [VPN_W-1:0]  vpn;
  logic              read_hit;
  logic [DATA_W-1:0] read_data;
  logic              fill_en;
  logic [DATA_W-1:0] fill_data;
  logic              csr_en;
  logic [15:0]       csr_addr;
  logic [63:0]       csr_wdata;

  // reference model with four entries per set.
  logic              m_valid [64][4];
  logic [33:0]       m_tag   [64][4];
  logic [15:0]       m_asid  [64][4];
  logic [DATA_W-1:0] m_data  [64][4];
  logic [1:0]        m_rank  [64][4];
  logic [63:0]       page_val;
  logic [63:0]       flags_val;
  int                checks;
  int                errors;

  ctlb u_dut (
    .clk       (clk),
    .rst       (rst),
    .lookup_en (lookup_en),
    .stall     (stall),
    .vpn       (vpn),
    .read_hit  (read_hit),
    .read_data (read_data),
    .fill_en   (fill_en),
    .fill_data (fill_data),
    .csr_en    (csr_en),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // model helpers.
  // --------------------------------------------------
  function automatic logic [15:0] asid_now();
    return flags_val[0] ? (page_val[15:0] ^ 16'h0001) : 16'h0000;
  endfunction

  function automatic int find_entry(input logic [VPN_W-1:0] v);
    int s;
    int r;
    s = v[5:0];
    r = -1;
    for (int w = 0; w < 4; w++)
      if (m_valid[s][w] && m_tag[s][w] == v[VPN_W-1:6] &&
          (m_asid[s][w] == asid_now() || m_data[s][w][0]))
        r = w;
    return r;
  endfunction

  function automatic int lru_way(input int s);
    int r;
    r = 0;
    for (int w = 0; w < 4; w++)
      if (m_rank[s][w] == 2'd0)
        r = w;
    return r;
  endfunction

  // touched way goes to 3 and the ones above it drop.
  task automatic touch_entry(input int s, input int w);
    logic [1:0] old;
    old = m_rank[s][w];
    for (int k = 0; k < 4; k++)
      if (m_rank[s][k] > old)
        m_rank[s][k] = m_rank[s][k] - 2'd1;
    m_rank[s][w] = 2'd3;
  endtask

  task automatic place_entry(input logic [VPN_W-1:0] v, input logic [DATA_W-1:0] d);
    int s;
    int w;
    s = v[5:0];
    w = lru_way(s);
    touch_entry(s, w);
    m_valid[s][w] = 1'b1;
    m_tag[s][w]   = v[VPN_W-1:6];
    m_asid[s][w]  = asid_now();
    m_data[s][w]  = d;
  endtask

  function automatic logic [VPN_W-1:0] rand_vpn();
    return {8'($urandom), $urandom};
  endfunction

  // --------------------------------------------------
  // bus actions.
  // --------------------------------------------------
  task automatic lookup(input logic [VPN_W-1:0] v, input logic en, input logic st);
    int w;
    @(negedge clk);
    vpn       = v;
    lookup_en = en;
    stall     = st;
    #2;
    w = find_entry(v);
    check_eq("read_hit", read_hit, w >= 0);
    check_eq("read_data", read_data, (w >= 0) ? m_data[v[5:0]][w] : '0);
    if (en && !st && w >= 0)
      touch_entry(v[5:0], w);
    @(negedge clk);
    lookup_en = 1'b0;
    stall     = 1'b0;
  endtask

  // request, then n stalled cycles, then the write cycle.
  task automatic fill(input logic [VPN_W-1:0] v, input logic [DATA_W-1:0] d, input int n);
    @(negedge clk);
    vpn       = v;
    fill_en   = 1'b1;
    fill_data = d;
    @(negedge clk);
    fill_en = 1'b0;
    stall   = (n > 0);
    for (int i = 0; i < n; i++)
      @(negedge clk);
    stall = 1'b0;
    @(negedge clk);
    place_entry(v, d);
  endtask

  task automatic write_csr(input logic [15:0] addr, input logic [63:0] val);
    @(negedge clk);
    csr_en    = 1'b1;
    csr_addr  = addr;
    csr_wdata = val;
    @(negedge clk);
    csr_en = 1'b0;
    if (addr == ctlb_pkg::CSR_PAGE)
      page_val = val;
    if (addr == ctlb_pkg::CSR_MFLAGS)
      flags_val = val;
  endtask

  // --------------------------------------------------
  // directed tests.
  // --------------------------------------------------
  task automatic init_sweep_check();
    for (int s = 0; s < 64; s++)
      for (int w = 0; w < 4; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_rank[s][w]  = 2'(w);
      end
    for (int i = 0; i < 64; i++)
    begin
      vpn = rand_vpn();
      #2;
      check_eq("read_hit", read_hit, 1'b0);
      @(negedge clk);
    end
    for (int i = 0; i < 8; i++)
      lookup(rand_vpn(), 1'b1, 1'b0);
  endtask

  task automatic fill_then_hit();
    logic [VPN_W-1:0] v;
    v = rand_vpn();
    fill(v, $urandom & 32'hffff_fffe, 0);
    lookup(v, 1'b1, 1'b0);
    lookup({v[VPN_W-1:6] ^ 34'h1, v[5:0]}, 1'b1, 1'b0);
  endtask

  task automatic fill_four_and_evict(input logic [5:0] s, input int n_stall);
    logic [VPN_W-1:0] vs [4];
    logic [VPN_W-1:0] lru_vpn;
    logic [VPN_W-1:0] v;
    for (int i = 0; i < 4; i++)
    begin
      vs[i] = {rand_vpn() >> 6, s};
      fill(vs[i], $urandom & 32'hffff_fffe, 0);
    end
    for (int i = 0; i < 4; i++)
      lookup(vs[i], 1'b1, 1'b0);
    lookup(vs[2], 1'b1, 1'b0);
    lru_vpn = {m_tag[s][lru_way(s)], s};
    // a stalled touch must not save the lru entry.
    if (n_stall > 0)
      lookup(lru_vpn, 1'b1, 1'b1);
    v = {rand_vpn() >> 6, s};
    fill(v, $urandom & 32'hffff_fffe, n_stall);
    lookup(lru_vpn, 1'b1, 1'b0);
    lookup(v, 1'b1, 1'b0);
    for (int i = 0; i < 4; i++)
      lookup(vs[i], 1'b0, 1'b0);
  endtask

  task automatic asid_match();
    logic [VPN_W-1:0] v_ng;
    logic [VPN_W-1:0] v_g;
    logic [VPN_W-1:0] v_z;
    v_ng = rand_vpn();
    v_g  = rand_vpn();
    v_z  = rand_vpn();
    write_csr(ctlb_pkg::CSR_MFLAGS, 64'h1);
    write_csr(ctlb_pkg::CSR_PAGE, 64'h1234);
    fill(v_ng, $urandom & 32'hffff_fffe, 0);
    fill(v_g, $urandom | 32'h1, 0);
    lookup(v_ng, 1'b1, 1'b0);
    lookup(v_g, 1'b1, 1'b0);
    write_csr(ctlb_pkg::CSR_PAGE, 64'h5678);
    lookup(v_ng, 1'b1, 1'b0);
    lookup(v_g, 1'b1, 1'b0);
    write_csr(ctlb_pkg::CSR_PAGE, 64'h1234);
    lookup(v_ng, 1'b1, 1'b0);
    // flags clear means asid 0.
    write_csr(ctlb_pkg::CSR_MFLAGS, 64'h0);
    lookup(v_ng, 1'b1, 1'b0);
    lookup(v_g, 1'b1, 1'b0);
    fill(v_z, $urandom & 32'hffff_fffe, 0);
    lookup(v_z, 1'b1, 1'b0);
    write_csr(ctlb_pkg::CSR_PAGE, 64'h0001);
    write_csr(ctlb_pkg::CSR_MFLAGS, 64'h1);
    lookup(v_z, 1'b1, 1'b0);
    lookup(v_ng, 1'b1, 1'b0);
  endtask

  initial
  begin
    rst       = 1'b1;
    lookup_en = 1'b0;
    stall     = 1'b0;
    vpn       = '0;
    fill_en   = 1'b0;
    fill_data = '0;
    csr_en    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    page_val  = '0;
    flags_val = '0;
    checks    = 0;
    errors    = 0;
    void'($urandom(32'h22d6_0d4f));
    repeat (3) @(negedge clk);
    rst = 1'b0;
    init_sweep_check();
    fill_then_hit();
    fill_four_and_evict(6'h15, 0);
    asid_match();
    fill_four_and_evict(6'h2b, 3);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- ctlb.f
logic/ctlb_pkg.sv
logic/ctlb_lookup_if.sv
logic/ctlb_ram.sv
logic/ctlb_rank.sv
logic/csr_watch.sv
logic/ctlb_way.sv
logic/ctlb.sv
verification/ctlb_tb.sv
